/* design/host_pkg.sv */
package host_pkg;

  // Bus widths
  localparam int ADDR_W = 14;
  localparam int DATA_W = 32;

  // L2 geometry
  localparam int NB_L2_BANKS   = 4;
  localparam int L2_BANK_WORDS = 256;
  localparam int L2_WORDS      = NB_L2_BANKS * L2_BANK_WORDS;
  localparam int BANK_SEL_W    = $clog2(NB_L2_BANKS);
  localparam int BANK_ROW_W    = $clog2(L2_BANK_WORDS);

  // Control register block
  localparam int NB_REGS   = 4;
  localparam int REG_IDX_W = $clog2(NB_REGS);
  localparam int CTRL_W    = 2;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [BANK_SEL_W-1:0] bank_sel_t;
  typedef logic [BANK_ROW_W-1:0] bank_row_t;
  typedef logic [REG_IDX_W-1:0]  reg_idx_t;

  // Word address map
  localparam addr_t L2_BASE  = 14'h0000;
  localparam addr_t L2_LAST  = L2_BASE + addr_t'(L2_WORDS - 1);
  localparam addr_t REG_BASE = 14'h2000;
  localparam addr_t REG_LAST = REG_BASE + addr_t'(NB_REGS - 1);

  // Register offsets inside the block
  localparam reg_idx_t REG_CTRL    = 2'd0;
  localparam reg_idx_t REG_GWT     = 2'd1;
  localparam reg_idx_t REG_EVT_CNT = 2'd2;
  localparam reg_idx_t REG_ID      = 2'd3;

  // CTRL bit positions
  localparam int CTRL_FETCH_EN_BIT = 0;
  localparam int CTRL_SA_BOOT_BIT  = 1;

  localparam data_t HOST_ID = 32'h48D0_0001;

  typedef enum logic [1:0] {TGT_NONE, TGT_L2, TGT_REG} target_e;

endpackage

/* design/mem_req_if.sv */
`timescale 1ns/1ns

interface mem_req_if;
  import host_pkg::*;

  // Request side
  logic  req;
  logic  we;
  addr_t addr;
  data_t wdata;

  // Read response, valid one cycle after the request
  data_t rdata;
  logic  rvalid;

  modport master (
    output req,
    output we,
    output addr,
    output wdata,
    input  rdata,
    input  rvalid
  );

  modport slave (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output rdata,
    output rvalid
  );

endinterface

/* design/host_addr_decoder.sv */
`timescale 1ns/1ns

module host_addr_decoder (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            req_i,
  input  logic            we_i,
  input  host_pkg::addr_t addr_i,
  input  host_pkg::data_t wdata_i,
  output host_pkg::data_t rdata_o,
  output logic            rvalid_o,
  output logic            err_o,
  mem_req_if.master       l2_o,
  mem_req_if.master       reg_o
);
  import host_pkg::*;

  target_e tgt_d;
  target_e tgt_q;
  logic    err_q;
  logic    err_rd_q;

  // Address map lookup
  always_comb begin
    tgt_d = TGT_NONE;
    if ((addr_i >= L2_BASE) && (addr_i <= L2_LAST)) begin
      tgt_d = TGT_L2;
    end else if ((addr_i >= REG_BASE) && (addr_i <= REG_LAST)) begin
      tgt_d = TGT_REG;
    end
  end

  // Forward path, no added cycle
  assign l2_o.req    = req_i && (tgt_d == TGT_L2);
  assign l2_o.we     = we_i;
  assign l2_o.addr   = addr_i;
  assign l2_o.wdata  = wdata_i;

  assign reg_o.req   = req_i && (tgt_d == TGT_REG);
  assign reg_o.we    = we_i;
  assign reg_o.addr  = addr_i;
  assign reg_o.wdata = wdata_i;

  // Remember where the response of this cycle comes from
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tgt_q    <= TGT_NONE;
      err_q    <= 1'b0;
      err_rd_q <= 1'b0;
    end else begin
      tgt_q    <= req_i ? tgt_d : TGT_NONE;
      err_q    <= req_i && (tgt_d == TGT_NONE);
      err_rd_q <= req_i && (tgt_d == TGT_NONE) && !we_i;
    end
  end

  // Response mux, unmapped reads answer with zero
  always_comb begin
    case (tgt_q)
      TGT_L2: begin
        rdata_o  = l2_o.rdata;
        rvalid_o = l2_o.rvalid;
      end
      TGT_REG: begin
        rdata_o  = reg_o.rdata;
        rvalid_o = reg_o.rvalid;
      end
      default: begin
        rdata_o  = '0;
        rvalid_o = err_rd_q;
      end
    endcase
  end

  assign err_o = err_q;

  // A target only answers in the cycle the mux listens to it
  a_resp_tracked: assert property (@(posedge clk_i) disable iff (rst_i)
    (l2_o.rvalid -> (tgt_q == TGT_L2)) && (reg_o.rvalid -> (tgt_q == TGT_REG)));

endmodule

/* design/l2_interleaved_mem.sv */
`timescale 1ns/1ns

module l2_interleaved_mem (
  input  logic     clk_i,
  input  logic     rst_i,
  mem_req_if.slave bus_i
);
  import host_pkg::*;

  addr_t     word_off;
  bank_sel_t bank_sel;
  bank_row_t bank_row;
  bank_sel_t bank_q;
  logic      rd_en;
  logic      rvalid_q;
  data_t     bank_rdata [NB_L2_BANKS];

  // Low bits pick the bank so that neighbouring words land in different banks
  assign word_off = bus_i.addr - L2_BASE;
  assign bank_sel = word_off[BANK_SEL_W-1:0];
  assign bank_row = word_off[BANK_SEL_W +: BANK_ROW_W];
  assign rd_en    = bus_i.req && !bus_i.we;

  for (genvar b = 0; b < NB_L2_BANKS; b++) begin : g_bank
    data_t bank_mem [L2_BANK_WORDS];
    logic  bank_req;

    assign bank_req = bus_i.req && (bank_sel == bank_sel_t'(b));

    // Each bank has its own output register
    always_ff @(posedge clk_i) begin
      if (bank_req) begin
        if (bus_i.we) begin
          bank_mem[bank_row] <= bus_i.wdata;
        end else begin
          bank_rdata[b] <= bank_mem[bank_row];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
      bank_q   <= '0;
    end else begin
      rvalid_q <= rd_en;
      if (rd_en) begin
        bank_q <= bank_sel;
      end
    end
  end

  // Response from the bank read in the previous cycle
  assign bus_i.rdata  = bank_rdata[bank_q];
  assign bus_i.rvalid = rvalid_q;

  a_addr_known: assert property (@(posedge clk_i) disable iff (rst_i)
    bus_i.req |-> !$isunknown(bus_i.addr));

endmodule

/* design/soc_ctrl_regs.sv */
`timescale 1ns/1ns

module soc_ctrl_regs (
  input  logic            clk_i,
  input  logic            rst_i,
  mem_req_if.slave        bus_i,
  input  logic            evt_pulse_i,
  input  host_pkg::data_t gwt_cfg_i,
  input  logic            gwt_cfg_ie_i,
  output host_pkg::data_t gwt_cfg_o,
  output logic            cluster_fetch_en_o,
  output logic            cluster_en_sa_boot_o
);
  import host_pkg::*;

  reg_idx_t          reg_idx;
  logic              wr_en;
  logic              rd_en;
  logic [CTRL_W-1:0] ctrl_q;
  data_t             gwt_q;
  data_t             evt_cnt_q;
  data_t             rdata_d;
  data_t             rdata_q;
  logic              rvalid_q;

  assign reg_idx = reg_idx_t'(bus_i.addr - REG_BASE);
  assign wr_en   = bus_i.req && bus_i.we;
  assign rd_en   = bus_i.req && !bus_i.we;

  // CTRL keeps only the two enable bits
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ctrl_q <= '0;
    end else if (wr_en && (reg_idx == REG_CTRL)) begin
      ctrl_q <= bus_i.wdata[CTRL_W-1:0];
    end
  end

  // External load beats a bus write
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gwt_q <= '0;
    end else if (gwt_cfg_ie_i) begin
      gwt_q <= gwt_cfg_i;
    end else if (wr_en && (reg_idx == REG_GWT)) begin
      gwt_q <= bus_i.wdata;
    end
  end

  // Cluster event count, any write clears it
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      evt_cnt_q <= '0;
    end else if (wr_en && (reg_idx == REG_EVT_CNT)) begin
      evt_cnt_q <= '0;
    end else if (evt_pulse_i) begin
      evt_cnt_q <= evt_cnt_q + 1'b1;
    end
  end

  // Read mux
  always_comb begin
    case (reg_idx)
      REG_CTRL:    rdata_d = data_t'(ctrl_q);
      REG_GWT:     rdata_d = gwt_q;
      REG_EVT_CNT: rdata_d = evt_cnt_q;
      REG_ID:      rdata_d = HOST_ID;
      default:     rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rdata_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_en;
    end
  end

  assign bus_i.rdata  = rdata_q;
  assign bus_i.rvalid = rvalid_q;

  assign gwt_cfg_o            = gwt_q;
  assign cluster_fetch_en_o   = ctrl_q[CTRL_FETCH_EN_BIT];
  assign cluster_en_sa_boot_o = ctrl_q[CTRL_SA_BOOT_BIT];

  // Only addresses of the register window reach this block
  a_addr_in_window: assert property (@(posedge clk_i) disable iff (rst_i)
    bus_i.req |-> ((bus_i.addr >= REG_BASE) && (bus_i.addr <= REG_LAST)));

endmodule

/* design/edge_propagator_rx.sv */
`timescale 1ns/1ns

module edge_propagator_rx (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic valid_o,
  output logic ack_o
);

  logic [1:0] sync_q;
  logic       level_q;

  // Two-stage synchronizer, then one more stage for the edge
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q  <= '0;
      level_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], valid_i};
      level_q <= sync_q[1];
    end
  end

  // One pulse for every toggle, rising or falling
  assign valid_o = sync_q[1] ^ level_q;

  // Sender may toggle again once this matches its own level
  assign ack_o = level_q;

  // Holds as long as the sender waits for the acknowledge
  a_single_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o |=> !valid_o);

endmodule

/* design/host_domain.sv */
`timescale 1ns/1ns

module host_domain (
  input  logic            clk_i,
  input  logic            rst_i,

  // Word request from the external master
  input  logic            req_i,
  input  logic            we_i,
  input  host_pkg::addr_t addr_i,
  input  host_pkg::data_t wdata_i,
  output host_pkg::data_t rdata_o,
  output logic            rvalid_o,
  output logic            err_o,

  // Event handshake with the cluster domain
  input  logic            dma_pe_evt_valid_i,
  output logic            dma_pe_evt_ack_o,

  // GWT configuration
  input  host_pkg::data_t gwt_cfg_i,
  input  logic            gwt_cfg_ie_i,
  output host_pkg::data_t gwt_cfg_o,

  // Cluster boot control
  output logic            cluster_fetch_en_o,
  output logic            cluster_en_sa_boot_o
);

  mem_req_if l2_bus ();
  mem_req_if reg_bus ();

  logic evt_pulse;

  host_addr_decoder i_addr_decoder (
    .clk_i    ( clk_i    ),
    .rst_i    ( rst_i    ),
    .req_i    ( req_i    ),
    .we_i     ( we_i     ),
    .addr_i   ( addr_i   ),
    .wdata_i  ( wdata_i  ),
    .rdata_o  ( rdata_o  ),
    .rvalid_o ( rvalid_o ),
    .err_o    ( err_o    ),
    .l2_o     ( l2_bus   ),
    .reg_o    ( reg_bus  )
  );

  l2_interleaved_mem i_l2_mem (
    .clk_i ( clk_i  ),
    .rst_i ( rst_i  ),
    .bus_i ( l2_bus )
  );

  soc_ctrl_regs i_soc_ctrl_regs (
    .clk_i                ( clk_i                ),
    .rst_i                ( rst_i                ),
    .bus_i                ( reg_bus              ),
    .evt_pulse_i          ( evt_pulse            ),
    .gwt_cfg_i            ( gwt_cfg_i            ),
    .gwt_cfg_ie_i         ( gwt_cfg_ie_i         ),
    .gwt_cfg_o            ( gwt_cfg_o            ),
    .cluster_fetch_en_o   ( cluster_fetch_en_o   ),
    .cluster_en_sa_boot_o ( cluster_en_sa_boot_o )
  );

  // Cluster DMA event crosses into this clock domain here
  edge_propagator_rx i_ep_dma_pe_evt (
    .clk_i   ( clk_i              ),
    .rst_i   ( rst_i              ),
    .valid_i ( dma_pe_evt_valid_i ),
    .valid_o ( evt_pulse          ),
    .ack_o   ( dma_pe_evt_ack_o   )
  );

endmodule

/* bench/host_domain_tb.sv */
`timescale 1ns/1ns

module host_domain_tb;
  import host_pkg::*;

  localparam int MAX_CYCLES = 4000;
  localparam int NB_EVENTS  = 8;

  typedef struct packed {
    int    stamp;
    logic  rvalid;
    logic  err;
    data_t rdata;
  } exp_t;

  logic  clk_i;
  logic  rst_i;
  logic  req_i;
  logic  we_i;
  addr_t addr_i;
  data_t wdata_i;
  data_t rdata_o;
  logic  rvalid_o;
  logic  err_o;
  logic  dma_pe_evt_valid_i;
  logic  dma_pe_evt_ack_o;
  data_t gwt_cfg_i;
  logic  gwt_cfg_ie_i;
  data_t gwt_cfg_o;
  logic  cluster_fetch_en_o;
  logic  cluster_en_sa_boot_o;

  // Shadow state of the L2 and the registers
  data_t      l2_sh [L2_WORDS];
  bit         l2_valid [L2_WORDS];
  logic [1:0] ctrl_sh = '0;
  data_t      gwt_sh = '0;
  data_t      evt_sh = '0;

  exp_t  exp_q [$];
  int    cycle_cnt = 0;
  data_t lcg_state = 32'd58;

  host_domain DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic data_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic reg_idx_t reg_index(input addr_t a);
    return reg_idx_t'(int'(a) - int'(REG_BASE));
  endfunction

  // Expected read data, error flag and target for one address
  function automatic void ref_read(input addr_t a, output data_t d, output logic err,
                                   output target_e tgt);
    d   = '0;
    err = 1'b0;
    tgt = TGT_NONE;
    if (int'(a) >= int'(L2_BASE) && int'(a) < int'(L2_BASE) + L2_WORDS) begin
      tgt = TGT_L2;
      d   = l2_sh[int'(a) - int'(L2_BASE)];
    end else if (int'(a) >= int'(REG_BASE) && int'(a) < int'(REG_BASE) + NB_REGS) begin
      tgt = TGT_REG;
      case (reg_index(a))
        REG_CTRL:    d = {30'b0, ctrl_sh};
        REG_GWT:     d = gwt_sh;
        REG_EVT_CNT: d = evt_sh;
        default:     d = HOST_ID;
      endcase
    end else begin
      err = 1'b1;
    end
  endfunction

  task automatic check_value(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("error: %s = 0x%h, expected 0x%h", name, got, exp);
      $display("Test FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // One request per call, queued for the compare process
  task automatic drive(input logic we, input addr_t a, input data_t d);
    exp_t    e;
    data_t   rd;
    logic    er;
    target_e tgt;
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= we;
    addr_i  <= a;
    wdata_i <= d;
    ref_read(a, rd, er, tgt);
    e.stamp  = cycle_cnt + 2;
    e.rvalid = !we;
    e.err    = er;
    e.rdata  = rd;
    exp_q.push_back(e);
    if (we && tgt == TGT_L2) begin
      l2_sh[int'(a) - int'(L2_BASE)]    = d;
      l2_valid[int'(a) - int'(L2_BASE)] = 1'b1;
    end else if (we && tgt == TGT_REG) begin
      case (reg_index(a))
        REG_CTRL:    ctrl_sh = d[1:0];
        REG_GWT:     gwt_sh  = d;
        REG_EVT_CNT: evt_sh  = '0;
        default:     ;
      endcase
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      req_i <= 1'b0;
      we_i  <= 1'b0;
    end
  endtask

  // Release the bus and stop where the outputs are stable
  task automatic settle();
    idle(1);
    @(negedge clk_i);
  endtask

  // Limit leaves ample margin over the length of the sequence
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test FAILED");
      $fatal(1, "timeout");
    end
  end

  // Response of a request shows up one cycle after the DUT samples it
  always @(negedge clk_i) begin : compare_proc
    exp_t e;
    e = '0;
    if (!rst_i) begin
      if (exp_q.size() > 0 && exp_q[0].stamp < cycle_cnt) begin
        $display("a queued response was never compared");
        $display("Test FAILED");
        $fatal(1, "lost response");
      end
      if (exp_q.size() > 0 && exp_q[0].stamp == cycle_cnt) begin
        e = exp_q.pop_front();
      end
      check_value("rvalid_o", data_t'(rvalid_o), data_t'(e.rvalid));
      check_value("err_o", data_t'(err_o), data_t'(e.err));
      if (e.rvalid) begin
        check_value("rdata_o", rdata_o, e.rdata);
      end
    end
  end

  initial begin : stimulus
    data_t r;
    data_t x;
    data_t x2;
    addr_t a;
    logic  lvl;
    rst_i              <= 1'b1;
    req_i              <= 1'b0;
    we_i               <= 1'b0;
    addr_i             <= '0;
    wdata_i            <= '0;
    dma_pe_evt_valid_i <= 1'b0;
    gwt_cfg_i          <= '0;
    gwt_cfg_ie_i       <= 1'b0;
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    check_value("rvalid_o", data_t'(rvalid_o), '0);
    check_value("err_o", data_t'(err_o), '0);
    check_value("cluster_fetch_en_o", data_t'(cluster_fetch_en_o), '0);
    check_value("cluster_en_sa_boot_o", data_t'(cluster_en_sa_boot_o), '0);
    check_value("gwt_cfg_o", gwt_cfg_o, '0);
    check_value("dma_pe_evt_ack_o", data_t'(dma_pe_evt_ack_o), '0);

    // L2 bursts of 8 words cover every bank twice
    for (int b = 0; b < 20; b++) begin
      r = lcg_next();
      a = addr_t'({r[31:25], 3'b000});
      for (int k = 0; k < 8; k++) begin
        drive(1'b1, a + addr_t'(k), lcg_next());
      end
      for (int k = 0; k < 8; k++) begin
        drive(1'b0, a + addr_t'(k), '0);
      end
    end
    for (int i = 0; i < 280; i++) begin
      r = lcg_next();
      a = addr_t'(r[31:22]);
      if (r[12] || !l2_valid[a]) begin
        drive(1'b1, a, lcg_next());
      end else begin
        drive(1'b0, a, '0);
      end
    end

    // CTRL enables and the read-only ID
    for (int i = 0; i < 4; i++) begin
      r = lcg_next();
      drive(1'b1, REG_BASE + addr_t'(REG_CTRL), {r[31:2], 2'(i)});
      settle();
      check_value("cluster_fetch_en_o", data_t'(cluster_fetch_en_o), data_t'(ctrl_sh[0]));
      check_value("cluster_en_sa_boot_o", data_t'(cluster_en_sa_boot_o), data_t'(ctrl_sh[1]));
      drive(1'b0, REG_BASE + addr_t'(REG_CTRL), '0);
    end
    drive(1'b1, REG_BASE + addr_t'(REG_ID), lcg_next());
    drive(1'b0, REG_BASE + addr_t'(REG_ID), '0);

    // GWT from the bus, then the external load against a bus write
    x = lcg_next();
    drive(1'b1, REG_BASE + addr_t'(REG_GWT), x);
    settle();
    check_value("gwt_cfg_o", gwt_cfg_o, x);
    drive(1'b0, REG_BASE + addr_t'(REG_GWT), '0);
    x  = lcg_next();
    x2 = lcg_next();
    drive(1'b1, REG_BASE + addr_t'(REG_GWT), lcg_next());
    gwt_cfg_ie_i <= 1'b1;
    gwt_cfg_i    <= x;
    gwt_sh = x;
    idle(1);
    gwt_cfg_i <= x2;
    gwt_sh = x2;
    @(negedge clk_i);
    check_value("gwt_cfg_o", gwt_cfg_o, x);
    @(posedge clk_i);
    gwt_cfg_ie_i <= 1'b0;
    @(negedge clk_i);
    check_value("gwt_cfg_o", gwt_cfg_o, x2);
    drive(1'b0, REG_BASE + addr_t'(REG_GWT), '0);
    idle(1);

    // Cluster events, each toggle waits for its acknowledge
    lvl = 1'b0;
    for (int i = 0; i < NB_EVENTS; i++) begin
      @(posedge clk_i);
      lvl = ~lvl;
      dma_pe_evt_valid_i <= lvl;
      evt_sh = evt_sh + 1;
      do @(negedge clk_i); while (dma_pe_evt_ack_o !== lvl);
    end
    drive(1'b0, REG_BASE + addr_t'(REG_EVT_CNT), '0);
    drive(1'b1, REG_BASE + addr_t'(REG_EVT_CNT), lcg_next());
    drive(1'b0, REG_BASE + addr_t'(REG_EVT_CNT), '0);

    // Unmapped accesses in both holes of the map
    for (int i = 0; i < 60; i++) begin
      r = lcg_next();
      if (r[8]) begin
        a = addr_t'(32'h0400 + (r[31:16] % 32'h1C00));
      end else begin
        a = addr_t'(32'h2004 + (r[31:16] % 32'h1FFC));
      end
      drive(r[15], a, lcg_next());
    end

    // Nothing above may have touched the L2 or the registers
    for (int w = 0; w < L2_WORDS; w++) begin
      if (l2_valid[w]) begin
        drive(1'b0, L2_BASE + addr_t'(w), '0);
      end
    end
    for (int i = 0; i < NB_REGS; i++) begin
      drive(1'b0, REG_BASE + addr_t'(i), '0);
    end
    idle(2);
    while (exp_q.size() > 0) begin
      @(negedge clk_i);
    end
    $display("Test OK");
    $finish;
  end

endmodule

/* filelist.f */
design/host_pkg.sv
design/mem_req_if.sv
design/host_addr_decoder.sv
design/l2_interleaved_mem.sv
design/soc_ctrl_regs.sv
design/edge_propagator_rx.sv
design/host_domain.sv
bench/host_domain_tb.sv
